/* Makefile */
TOP := rtc_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* calendar_date.sv */
`timescale 1ns/1ps
`default_nettype none

module calendar_date
   import rtc_pkg::*;
(
   input  wire            secclk,
   input  wire            arst_n,
   input  wire            day_inc,
   input  wire            load,
   input  wire rtc_date_t load_date,
   output rtc_date_t      date
);

   logic     wd_fix;
   logic     advance;
   weekday_t zel_wd;

   function automatic logic is_leap(input year_t y);
      return (((y % 4) == 0) && ((y % 100) != 0)) || ((y % 400) == 0);
   endfunction

   function automatic day_t month_len(input month_t m, input year_t y);
      day_t len;
      case (m)
         4'd2:                    len = is_leap(y) ? 5'd29 : 5'd28;
         4'd4, 4'd6, 4'd9, 4'd11: len = 5'd30;
         default:                 len = 5'd31;
      endcase
      return len;
   endfunction

   // Zeller's congruence; January and February count as months 13 and 14
   // of the year before. Its result has 0 for Saturday, shifted here to Sunday.
   function automatic weekday_t zeller(input day_t d, input month_t m, input year_t y);
      int unsigned mm;
      int unsigned yy;
      int unsigned h;
      if (m < 4'd3)
      begin
         mm = m + 12;
         yy = y - 1;
      end
      else
      begin
         mm = m;
         yy = y;
      end
      h = (d + (13 * (mm + 1)) / 5 + yy + yy / 4 - yy / 100 + yy / 400) % 7;
      return weekday_t'((h + 6) % 7);
   endfunction

   function automatic weekday_t wd_step(input weekday_t w);
      return (w == 3'd6) ? 3'd0 : w + 1'b1;
   endfunction

   assign advance = day_inc && !load;
   assign zel_wd  = zeller(date.day, date.month, date.year);

   // ############################################################
   // Date registers
   // ############################################################

   always_ff @(posedge secclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         date   <= RESET_DATE;
         wd_fix <= 1'b0;
      end
      else
      begin
         wd_fix <= load;
         if (load)
         begin
            date.year  <= load_date.year;
            date.month <= load_date.month;
            date.day   <= load_date.day;
         end
         else if (day_inc)
         begin
            if (date.day >= month_len(date.month, date.year))
            begin
               date.day <= 5'd1;
               if (date.month == 4'd12)
               begin
                  date.month <= 4'd1;
                  date.year  <= date.year + 1'b1;
               end
               else
                  date.month <= date.month + 1'b1;
            end
            else
               date.day <= date.day + 1'b1;
         end

         // The weekday follows a written date one cycle late.
         if (wd_fix)
            date.weekday <= advance ? wd_step(zel_wd) : zel_wd;
         else if (advance)
            date.weekday <= wd_step(date.weekday);
      end
   end

endmodule

`default_nettype wire

/* list.f */
rtc_pkg.sv
tick_prescaler.sv
time_unit_counter.sv
calendar_date.sv
rtc_wb_regs.sv
rtc_top.sv
rtc_checker.sv
tb_clock_gen.sv
rtc_tb.sv

/* rtc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_checker
   import rtc_pkg::*;
(
   input wire            secclk,
   input wire            arst_n,
   input wire            cyc,
   input wire            stb,
   input wire            ack,
   input wire            run,
   input wire            quick,
   input wire            sec_pulse,
   input wire rtc_time_t now_time,
   input wire rtc_date_t now_date
);

   // A request seen with ack low is answered on the next edge.
   ack_follows_request: assert property (@(posedge secclk) disable iff (!arst_n)
      (cyc && stb && !ack) |=> ack)
      else $error("ack did not follow a request");

   // A stopped divider restarts from its reload value, so no tick comes at once.
   no_tick_after_stop: assert property (@(posedge secclk) disable iff (!arst_n)
      !run |=> (!sec_pulse || quick))
      else $error("sec_pulse fired right after run was clear");

   time_in_range: assert property (@(posedge secclk) disable iff (!arst_n)
      now_time.second < 6'd60 && now_time.minute < 6'd60 && now_time.hour < 6'd24)
      else $error("time field out of range");

   month_in_range: assert property (@(posedge secclk) disable iff (!arst_n)
      now_date.month >= 4'd1 && now_date.month <= 4'd12)
      else $error("month out of range");

endmodule

bind rtc_top rtc_checker u_checker (
   .secclk    (secclk),
   .arst_n    (arst_n),
   .cyc       (cyc),
   .stb       (stb),
   .ack       (ack),
   .run       (run),
   .quick     (quick),
   .sec_pulse (sec_pulse),
   .now_time  (now_time),
   .now_date  (now_date)
);

`default_nettype wire

/* rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

   // ############################################################
   // Field widths
   // ############################################################

   typedef logic [5:0]  unit_val_t;
   typedef logic [4:0]  day_t;
   typedef logic [3:0]  month_t;
   typedef logic [15:0] year_t;
   typedef logic [2:0]  weekday_t;
   typedef logic [1:0]  wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // Second sits in the low bits so the struct also reads as an array of
   // unit values indexed from seconds upward.
   typedef struct packed {
      unit_val_t hour;
      unit_val_t minute;
      unit_val_t second;
   } rtc_time_t;

   typedef struct packed {
      year_t    year;
      month_t   month;
      day_t     day;
      weekday_t weekday;
   } rtc_date_t;

   localparam int NUM_UNITS = 3;
   localparam int UNIT_MOD [NUM_UNITS] = '{60, 60, 24};

   // ############################################################
   // Reset values and register map
   // ############################################################

   localparam rtc_time_t RESET_TIME = '{hour: 6'd11, minute: 6'd59, second: 6'd58};
   localparam rtc_date_t RESET_DATE = '{year: 16'd2023, month: 4'd5, day: 5'd9,
                                        weekday: 3'd2};

   localparam wb_addr_t REG_TIME    = 2'd0;
   localparam wb_addr_t REG_DATE    = 2'd1;
   localparam wb_addr_t REG_WEEKDAY = 2'd2;
   localparam wb_addr_t REG_CTRL    = 2'd3;

endpackage

`default_nettype wire

/* rtc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_tb
   import rtc_pkg::*;
();

   localparam int TICK_DIV       = 16;
   localparam int REG_ROUNDS     = 12;
   localparam int QUICK_SEGMENTS = 6;
   localparam int QUICK_LEN      = 500;
   // Well above the few thousand cycles that all tests take together.
   localparam int TIMEOUT_CYCLES = 20000;

   // Boundary dates and the day that follows each of them.
   localparam int BND_YEAR [6]   = '{2000, 1900, 2024, 2023, 2023, 2023};
   localparam int BND_MONTH [6]  = '{2, 2, 2, 2, 12, 4};
   localparam int BND_DAY [6]    = '{28, 28, 28, 28, 31, 30};
   localparam int NEXT_YEAR [6]  = '{2000, 1900, 2024, 2023, 2024, 2023};
   localparam int NEXT_MONTH [6] = '{2, 3, 2, 3, 1, 5};
   localparam int NEXT_DAY [6]   = '{29, 1, 29, 1, 1, 1};

   logic      secclk;
   logic      arst_n;
   logic      cyc;
   logic      stb;
   logic      we;
   wb_addr_t  adr;
   wb_data_t  dat_w;
   wb_data_t  dat_r;
   logic      ack;
   rtc_time_t now_time;
   rtc_date_t now_date;
   logic      sec_pulse;

   integer seed;
   string  test_name;
   bit     track;
   bit     hold_still;
   int     m_sec;
   int     m_min;
   int     m_hour;
   int     m_day;
   int     m_month;
   int     m_year;
   int     m_wday;
   int     pulse_count;
   int     last_pulse_cycle;
   int     error_count;
   int     cycle_count = 0;

   tb_clock_gen #(
      .PERIOD       (10),
      .RESET_CYCLES (5)
   ) u_clk (
      .secclk (secclk),
      .arst_n (arst_n)
   );

   rtc_top #(
      .TICK_DIV (TICK_DIV)
   ) uut (
      .secclk    (secclk),
      .arst_n    (arst_n),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_w     (dat_w),
      .dat_r     (dat_r),
      .ack       (ack),
      .now_time  (now_time),
      .now_date  (now_date),
      .sec_pulse (sec_pulse)
   );

   always @(posedge secclk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   end

   // ############################################################
   // Reference calendar model
   // ############################################################

   function automatic int rand_range(input int lo, input int hi);
      int span;
      span = hi - lo + 1;
      return lo + int'($unsigned($random(seed)) % span);
   endfunction

   function automatic int days_in_month(input int mo, input int y);
      bit leap;
      leap = (y % 400 == 0) || ((y % 4 == 0) && (y % 100 != 0));
      if (mo == 2)
         return leap ? 29 : 28;
      else if (mo == 4 || mo == 6 || mo == 9 || mo == 11)
         return 30;
      return 31;
   endfunction

   // Zeller with century split; h is 0 for Saturday, moved to 0 for Sunday.
   function automatic int day_of_week(input int d, input int mo, input int y);
      int k;
      int j;
      int h;
      if (mo < 3)
      begin
         mo = mo + 12;
         y  = y - 1;
      end
      k = y % 100;
      j = y / 100;
      h = (d + (13 * (mo + 1)) / 5 + k + k / 4 + j / 4 + 5 * j) % 7;
      return (h + 6) % 7;
   endfunction

   function automatic logic [31:0] time_value(input int h, input int mi, input int s);
      return {14'd0, 6'(h), 6'(mi), 6'(s)};
   endfunction

   function automatic logic [31:0] date_value(input int y, input int mo, input int d,
                                              input int w);
      return {4'd0, 16'(y), 4'(mo), 5'(d), 3'(w)};
   endfunction

   function automatic wb_data_t time_word(input int h, input int mi, input int s);
      return {11'd0, 5'(h), 2'd0, 6'(mi), 2'd0, 6'(s)};
   endfunction

   function automatic wb_data_t date_word(input int y, input int mo, input int d);
      return {16'(y), 4'd0, 4'(mo), 3'd0, 5'(d)};
   endfunction

   task automatic advance_second();
      m_sec = m_sec + 1;
      if (m_sec == 60)
      begin
         m_sec = 0;
         m_min = m_min + 1;
         if (m_min == 60)
         begin
            m_min  = 0;
            m_hour = m_hour + 1;
            if (m_hour == 24)
            begin
               m_hour = 0;
               m_wday = (m_wday + 1) % 7;
               m_day  = m_day + 1;
               if (m_day > days_in_month(m_month, m_year))
               begin
                  m_day   = 1;
                  m_month = m_month + 1;
                  if (m_month == 13)
                  begin
                     m_month = 1;
                     m_year  = m_year + 1;
                  end
               end
            end
         end
      end
   endtask

   // ############################################################
   // Checks, cycle stepping and bus access
   // ############################################################

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual == expected)
      else
      begin
         error_count++;
         $display("Error in test %s, %s: expected 0x%h, actual 0x%h",
                  test_name, what, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_true(input bit cond, input string msg);
      assert (cond)
      else
      begin
         error_count++;
         $display("Test %s: %s", test_name, msg);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   // Outputs are compared on the falling edge, where they are settled.
   task automatic step_cycle();
      @(negedge secclk);
      if (hold_still)
         check_true(!sec_pulse, "sec_pulse fired while run was clear");
      if (track)
      begin
         check_value("now_time", time_value(m_hour, m_min, m_sec), {14'd0, now_time});
         check_value("now_date", date_value(m_year, m_month, m_day, m_wday),
                     {4'd0, now_date});
      end
      if (sec_pulse)
      begin
         pulse_count      = pulse_count + 1;
         last_pulse_cycle = cycle_count;
         advance_second();
      end
   endtask

   task automatic wait_pulses(input int n);
      int target;
      int guard;
      target = pulse_count + n;
      guard  = 0;
      while (pulse_count < target)
      begin
         check_true(guard < n * 4 * TICK_DIV, "no seconds tick arrived in time");
         step_cycle();
         guard++;
      end
   endtask

   task automatic wait_ack();
      int waited;
      waited = 0;
      step_cycle();
      while (!ack)
      begin
         waited++;
         check_true(waited < 8, "no Wishbone ack within 8 cycles");
         step_cycle();
      end
   endtask

   task automatic bus_write(input wb_addr_t a, input wb_data_t d);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      dat_w = d;
      wait_ack();
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_read(input wb_addr_t a, output wb_data_t d);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      wait_ack();
      d   = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   // Written while stopped; the weekday settles one cycle after the date write.
   task automatic set_clock(input int h, input int mi, input int s, input int y,
                            input int mo, input int d);
      track = 1'b0;
      bus_write(REG_TIME, time_word(h, mi, s));
      bus_write(REG_DATE, date_word(y, mo, d));
      m_hour  = h;
      m_min   = mi;
      m_sec   = s;
      m_year  = y;
      m_month = mo;
      m_day   = d;
      m_wday  = day_of_week(d, mo, y);
      step_cycle();
      track = 1'b1;
   endtask

   initial
   begin
      int       rounds;
      int       h;
      int       mi;
      int       s;
      int       y;
      int       mo;
      int       d;
      int       prev;
      wb_data_t rd;

      seed             = 32'h1b648084;
      cyc              = 1'b0;
      stb              = 1'b0;
      we               = 1'b0;
      adr              = '0;
      dat_w            = '0;
      track            = 1'b0;
      hold_still       = 1'b0;
      pulse_count      = 0;
      last_pulse_cycle = 0;
      error_count      = 0;

      test_name = "reset";
      wait (arst_n === 1'b1);
      check_value("now_time", time_value(11, 59, 58), {14'd0, now_time});
      check_value("now_date", date_value(2023, 5, 9, 2), {4'd0, now_date});
      check_true(!ack, "ack is high after reset");
      check_true(!sec_pulse, "sec_pulse is high after reset");
      m_hour  = 11;
      m_min   = 59;
      m_sec   = 58;
      m_year  = 2023;
      m_month = 5;
      m_day   = 9;
      m_wday  = 2;
      track   = 1'b1;

      test_name = "register access";
      bus_write(REG_CTRL, 32'd0);
      hold_still = 1'b1;
      for (rounds = 0; rounds < REG_ROUNDS; rounds++)
      begin
         h  = rand_range(0, 23);
         mi = rand_range(0, 59);
         s  = rand_range(0, 59);
         y  = rand_range(1600, 9999);
         mo = rand_range(1, 12);
         d  = rand_range(1, days_in_month(mo, y));
         set_clock(h, mi, s, y, mo, d);
         bus_read(REG_TIME, rd);
         check_value("TIME register", time_word(h, mi, s), rd);
         bus_read(REG_DATE, rd);
         check_value("DATE register", date_word(y, mo, d), rd);
         bus_read(REG_WEEKDAY, rd);
         check_value("WEEKDAY register", 32'(day_of_week(d, mo, y)), rd);
      end

      test_name = "stop";
      repeat (rand_range(20, 80)) step_cycle();
      bus_read(REG_CTRL, rd);
      check_value("CTRL register", 32'd0, rd);
      h  = rand_range(0, 23);
      mi = rand_range(0, 59);
      set_clock(h, mi, 30, 2001, 7, 15);
      repeat (rand_range(20, 80)) step_cycle();
      bus_read(REG_TIME, rd);
      check_value("TIME register", time_word(h, mi, 30), rd);

      test_name = "quick run";
      for (rounds = 0; rounds < QUICK_SEGMENTS; rounds++)
      begin
         y  = rand_range(1600, 9999);
         mo = rand_range(1, 12);
         d  = days_in_month(mo, y) - rand_range(0, 1);
         mi = rand_range(52, 59);
         s  = rand_range(0, 59);
         set_clock(23, mi, s, y, mo, d);
         hold_still = 1'b0;
         bus_write(REG_CTRL, 32'd3);
         bus_read(REG_CTRL, rd);
         check_value("CTRL register", 32'd3, rd);
         repeat (QUICK_LEN) step_cycle();
         bus_write(REG_CTRL, 32'd0);
         hold_still = 1'b1;
      end

      test_name = "calendar boundary";
      for (rounds = 0; rounds < 6; rounds++)
      begin
         set_clock(23, 59, 50, BND_YEAR[rounds], BND_MONTH[rounds], BND_DAY[rounds]);
         prev       = day_of_week(BND_DAY[rounds], BND_MONTH[rounds], BND_YEAR[rounds]);
         hold_still = 1'b0;
         bus_write(REG_CTRL, 32'd3);
         wait_pulses(12);
         bus_write(REG_CTRL, 32'd0);
         hold_still = 1'b1;
         check_value("next day", date_value(NEXT_YEAR[rounds], NEXT_MONTH[rounds],
                     NEXT_DAY[rounds], (prev + 1) % 7), {4'd0, now_date});
      end

      test_name  = "normal divider";
      hold_still = 1'b0;
      bus_write(REG_CTRL, 32'd1);
      wait_pulses(1);
      for (rounds = 0; rounds < 6; rounds++)
      begin
         prev = last_pulse_cycle;
         wait_pulses(1);
         check_value("pulse spacing", 32'(TICK_DIV), 32'(last_pulse_cycle - prev));
      end

      if (error_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* rtc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_top
   import rtc_pkg::*;
#(
   parameter int TICK_DIV = 1000000
) (
   input  wire           secclk,
   input  wire           arst_n,
   input  wire           cyc,
   input  wire           stb,
   input  wire           we,
   input  wire wb_addr_t adr,
   input  wire wb_data_t dat_w,
   output wb_data_t      dat_r,
   output logic          ack,
   output rtc_time_t     now_time,
   output rtc_date_t     now_date,
   output logic          sec_pulse
);

   localparam unit_val_t [NUM_UNITS-1:0] RESET_UNITS = RESET_TIME;

   logic                        tick;
   logic                        run;
   logic                        quick;
   logic                        time_load;
   logic                        date_load;
   rtc_time_t                   time_wdata;
   rtc_date_t                   date_wdata;
   logic      [NUM_UNITS:0]     carry;
   unit_val_t [NUM_UNITS-1:0]   unit_val;
   unit_val_t [NUM_UNITS-1:0]   unit_load;

   tick_prescaler #(
      .TICK_DIV (TICK_DIV)
   ) u_prescaler (
      .secclk (secclk),
      .arst_n (arst_n),
      .run    (run),
      .quick  (quick),
      .tick   (tick)
   );

   // ############################################################
   // Seconds, minutes and hours chained by their carries
   // ############################################################

   assign carry[0]  = tick;
   assign unit_load = time_wdata;

   for (genvar i = 0; i < NUM_UNITS; i++)
   begin : g_unit
      time_unit_counter #(
         .MODULUS   (UNIT_MOD[i]),
         .RESET_VAL (RESET_UNITS[i])
      ) u_unit (
         .secclk    (secclk),
         .arst_n    (arst_n),
         .carry_in  (carry[i]),
         .load      (time_load),
         .load_val  (unit_load[i]),
         .value     (unit_val[i]),
         .carry_out (carry[i+1])
      );
   end

   calendar_date u_calendar (
      .secclk    (secclk),
      .arst_n    (arst_n),
      .day_inc   (carry[NUM_UNITS]),
      .load      (date_load),
      .load_date (date_wdata),
      .date      (now_date)
   );

   rtc_wb_regs u_regs (
      .secclk     (secclk),
      .arst_n     (arst_n),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .cur_time   (now_time),
      .cur_date   (now_date),
      .run        (run),
      .quick      (quick),
      .time_load  (time_load),
      .time_wdata (time_wdata),
      .date_load  (date_load),
      .date_wdata (date_wdata)
   );

   assign now_time  = unit_val;
   assign sec_pulse = tick;

endmodule

`default_nettype wire

/* rtc_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rtc_wb_regs
   import rtc_pkg::*;
(
   input  wire            secclk,
   input  wire            arst_n,
   input  wire            cyc,
   input  wire            stb,
   input  wire            we,
   input  wire wb_addr_t  adr,
   input  wire wb_data_t  dat_w,
   output wb_data_t       dat_r,
   output logic           ack,
   input  wire rtc_time_t cur_time,
   input  wire rtc_date_t cur_date,
   output logic           run,
   output logic           quick,
   output logic           time_load,
   output rtc_time_t      time_wdata,
   output logic           date_load,
   output rtc_date_t      date_wdata
);

   logic     req;
   logic     wr;
   wb_data_t rd_data;

   // A new request is one seen while ack is low, so ack never repeats.
   assign req = cyc && stb && !ack;
   assign wr  = req && we;

   assign time_load = wr && (adr == REG_TIME);
   assign date_load = wr && (adr == REG_DATE);

   assign time_wdata = '{hour:   {1'b0, dat_w[20:16]},
                         minute: dat_w[13:8],
                         second: dat_w[5:0]};

   assign date_wdata = '{year:    dat_w[31:16],
                         month:   dat_w[11:8],
                         day:     dat_w[4:0],
                         weekday: '0};

   // ############################################################
   // Handshake and control
   // ############################################################

   always_ff @(posedge secclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ack   <= 1'b0;
         run   <= 1'b1;
         quick <= 1'b0;
      end
      else
      begin
         ack <= req;
         if (wr && adr == REG_CTRL)
         begin
            run   <= dat_w[0];
            quick <= dat_w[1];
         end
      end
   end

   always_comb
   begin
      case (adr)
         REG_TIME:    rd_data = {11'd0, cur_time.hour[4:0], 2'd0, cur_time.minute,
                                 2'd0, cur_time.second};
         REG_DATE:    rd_data = {cur_date.year, 4'd0, cur_date.month, 3'd0, cur_date.day};
         REG_WEEKDAY: rd_data = {29'd0, cur_date.weekday};
         default:     rd_data = {30'd0, quick, run};
      endcase
   end

   // Read data is captured on the edge that raises ack.
   always_ff @(posedge secclk)
   begin
      if (req && !we)
         dat_r <= rd_data;
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 5
) (
   output logic secclk,
   output logic arst_n
);

   initial
   begin
      secclk = 1'b0;
      forever #(PERIOD / 2) secclk = ~secclk;
   end

   // Reset is released on a falling edge, away from the active edge.
   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge secclk);
      @(negedge secclk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tick_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_prescaler #(
   parameter int TICK_DIV = 1000
) (
   input  wire  secclk,
   input  wire  arst_n,
   input  wire  run,
   input  wire  quick,
   output logic tick
);

   localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   localparam logic [CW-1:0] RELOAD = CW'(TICK_DIV - 1);

   logic [CW-1:0] cnt;

   // The counter rests at its reload value whenever it is not needed.
   always_ff @(posedge secclk or negedge arst_n)
   begin
      if (!arst_n)
         cnt <= RELOAD;
      else if (!run || quick || cnt == '0)
         cnt <= RELOAD;
      else
         cnt <= cnt - 1'b1;
   end

   assign tick = run && (quick || cnt == '0);

endmodule

`default_nettype wire

/* time_unit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module time_unit_counter
   import rtc_pkg::*;
#(
   parameter int        MODULUS   = 60,
   parameter unit_val_t RESET_VAL = '0
) (
   input  wire            secclk,
   input  wire            arst_n,
   input  wire            carry_in,
   input  wire            load,
   input  wire unit_val_t load_val,
   output unit_val_t      value,
   output logic           carry_out
);

   localparam unit_val_t MAX_VAL = unit_val_t'(MODULUS - 1);

   logic at_max;

   assign at_max    = (value == MAX_VAL);
   assign carry_out = carry_in && at_max;

   // Load wins over a carry arriving in the same cycle.
   always_ff @(posedge secclk or negedge arst_n)
   begin
      if (!arst_n)
         value <= RESET_VAL;
      else if (load)
         value <= load_val;
      else if (carry_in)
      begin
         if (at_max)
            value <= '0;
         else
            value <= value + 1'b1;
      end
   end

endmodule

`default_nettype wire
